//--- bench/obj_engine_tb.sv
// testbench for the object line engine
// clock and reset, ROM model with random delays, test file reader,
// compare tasks for line buffer pixels and the line toggle
`timescale 1ns/1ps
`default_nettype none

module obj_engine_tb import obj_pkg::*; ;

    localparam int         TABLE_AW = 10;
    localparam logic [8:0] START_H  = 9'h1d0;
    localparam logic [BUF_W-1:0] EMPTY_PXL = BUF_W'(TRANSP);

    logic                 rst, clk, flip;
    logic [8:0]           vrender1, hdump, pxl_addr;
    logic [9:0]           off_x, off_y;
    logic                 cpu_we;
    logic [TABLE_AW+1:0]  cpu_addr;
    logic [15:0]          cpu_data;
    logic [22:0]          rom_addr;
    logic                 rom_cs, rom_ok;
    logic [31:0]          rom_data;
    logic [BUF_W-1:0]     pxl_data;
    logic                 line;

    logic [BUF_W-1:0]     expv [0:511];   // expected line contents
    logic [31:0]          rnd;
    logic [1:0]           rom_wait;
    logic                 rom_busy;
    int                   pxl_errs, line_errs, other_errs;

    obj_engine #(.TABLE_AW(TABLE_AW), .START_H(START_H)) obj_engine_i (
        .rst      (rst),
        .clk      (clk),
        .flip     (flip),
        .vrender1 (vrender1),
        .hdump    (hdump),
        .off_x    (off_x),
        .off_y    (off_y),
        .cpu_we   (cpu_we),
        .cpu_addr (cpu_addr),
        .cpu_data (cpu_data),
        .rom_addr (rom_addr),
        .rom_cs   (rom_cs),
        .rom_data (rom_data),
        .rom_ok   (rom_ok),
        .pxl_addr (pxl_addr),
        .pxl_data (pxl_data),
        .line     (line)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // pixel = code low nibble + pixel index + vsub
    function automatic logic [31:0] rom_word(input logic [22:0] a);
        logic [31:0] w;
        logic [3:0]  base;
        base = a[8:5] + a[4:1] + {a[0], 3'b000};
        for (int k = 0; k < 8; k++) begin
            w[k*4 +: 4] = base + 4'(k);
        end
        return w;
    endfunction

    // ROM answers 1 to 4 cycles after rom_cs
    initial begin
        rom_ok   = 1'b0;
        rom_data = '0;
        rom_busy = 1'b0;
        rom_wait = '0;
        rnd      = 32'd64;
        forever begin
            @(negedge clk);
            if (rst || !rom_cs) begin
                rom_ok   = 1'b0;
                rom_busy = 1'b0;
            end else if (!rom_ok) begin
                if (!rom_busy) begin
                    rnd      = xorshift(rnd);
                    rom_wait = rnd[1:0];
                    rom_busy = 1'b1;
                end
                if (rom_wait == 2'd0) begin
                    rom_data = rom_word(rom_addr);
                    rom_ok   = 1'b1;
                    rom_busy = 1'b0;
                end else begin
                    rom_wait = rom_wait - 2'd1;
                end
            end
        end
    end

    task automatic check_pxl(input logic [8:0] pos, input logic [BUF_W-1:0] got,
                             input logic [BUF_W-1:0] want);
        if (got !== want) begin
            pxl_errs++;
            $display("ERR pxl_data[%03h] got %03h exp %03h", pos, got, want);
        end
    endtask

    task automatic check_line(input logic got, input logic want);
        if (got !== want) begin
            line_errs++;
            $display("ERR line got %h exp %h", got, want);
        end
    endtask

    task automatic clear_expected;
        for (int a = 0; a < 512; a++) begin
            expv[a] = EMPTY_PXL;
        end
    endtask

    task automatic write_entry(input logic [31:0] ent, input logic [15:0] x,
                               input logic [15:0] y, input logic [15:0] code,
                               input logic [15:0] attr);
        logic [15:0] words [4];
        words[0] = x;
        words[1] = y;
        words[2] = code;
        words[3] = attr;
        for (int k = 0; k < 4; k++) begin
            @(negedge clk);
            cpu_we   = 1'b1;
            cpu_addr = {ent[TABLE_AW-1:0], 2'(k)};
            cpu_data = words[k];
        end
        @(negedge clk);
        cpu_we = 1'b0;
    endtask

    // sweep hdump through one line and wait for the toggle, then for drawing to stop
    task automatic run_line;
        logic want;
        int   t;
        int   quiet;
        want = ~line;
        for (int h = 0; h < 512; h++) begin
            @(negedge clk);
            hdump = 9'(h);
        end
        @(negedge clk);
        hdump = '0;
        t = 0;
        while (line !== want && t < 1000) begin
            @(negedge clk);
            t++;
        end
        check_line(line, want);
        quiet = 0;
        t     = 0;
        while (quiet < 64 && t < 5000) begin
            @(negedge clk);
            quiet = rom_cs ? 0 : quiet + 1;
            t++;
        end
        if (quiet < 64) begin
            other_errs++;
            $display("timeout: renderer still fetching from ROM");
        end
    endtask

    // one pass over all 512 slots with data one clock after the address
    task automatic read_pass(input logic erased);
        logic [BUF_W-1:0] want;
        for (int a = 0; a <= 512; a++) begin
            @(negedge clk);
            if (a > 0) begin
                want = erased ? EMPTY_PXL : expv[a-1];
                check_pxl(9'(a - 1), pxl_data, want);
            end
            if (a < 512) begin
                pxl_addr = 9'(a);
            end
        end
        pxl_addr = '0;
    endtask

    task automatic bad_line(input string s);
        other_errs++;
        $display("malformed line in test file: %s", s);
    endtask

    initial begin
        int          fd;
        int          nf;
        string       str;
        logic [31:0] f [5];
        logic [31:0] v [16];
        rst      = 1'b1;
        flip     = 1'b0;
        vrender1 = '0;
        hdump    = '0;
        off_x    = '0;
        off_y    = '0;
        cpu_we   = 1'b0;
        cpu_addr = '0;
        cpu_data = '0;
        pxl_addr = '0;
        pxl_errs   = 0;
        line_errs  = 0;
        other_errs = 0;
        clear_expected();
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        repeat (1100) @(negedge clk);   // line buffer sweep after reset
        check_line(line, 1'b0);
        fd = $fopen("bench/obj_tests.txt", "r");
        if (fd == 0) begin
            other_errs++;
            $display("cannot open test file bench/obj_tests.txt");
        end else begin
            while (!$feof(fd)) begin
                str = "";
                nf  = $fgets(str, fd);
                if (str.len() < 2 || str[0] == "#") begin
                    continue;
                end
                case (str[0])
                    "w": begin
                        nf = $sscanf(str, "w %h %h %h %h %h", f[0], f[1], f[2], f[3], f[4]);
                        if (nf != 5) begin
                            bad_line(str);
                        end else begin
                            write_entry(f[0], f[1][15:0], f[2][15:0], f[3][15:0], f[4][15:0]);
                        end
                    end
                    "s": begin
                        nf = $sscanf(str, "s %h %h %h %h", f[0], f[1], f[2], f[3]);
                        if (nf != 4) begin
                            bad_line(str);
                        end else begin
                            @(negedge clk);
                            flip     = f[0][0];
                            off_x    = f[1][9:0];
                            off_y    = f[2][9:0];
                            vrender1 = f[3][8:0];
                        end
                    end
                    "p": begin
                        nf = $sscanf(str,
                                     "p %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                     f[0], v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7],
                                     v[8], v[9], v[10], v[11], v[12], v[13], v[14], v[15]);
                        if (nf != 17) begin
                            bad_line(str);
                        end else begin
                            for (int k = 0; k < 16; k++) begin
                                if (f[0] + k < 512) begin
                                    // file words hold the palette from bit 5 up
                                    expv[f[0] + k] = {v[k][PXL_W+PAL_W:PXL_W+1],
                                                      v[k][PXL_W-1:0]};
                                end
                            end
                        end
                    end
                    "r": begin
                        run_line();     // scan and draw into the write half
                        run_line();     // that half now faces the display
                        read_pass(1'b0);
                        read_pass(1'b1);
                        clear_expected();
                    end
                    default: bad_line(str);
                endcase
            end
            $fclose(fd);
        end
        $display("errors: pxl_data %0d line %0d other %0d", pxl_errs, line_errs, other_errs);
        if (pxl_errs + line_errs + other_errs == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/obj_tests.txt
# w entry x y code attr | s flip off_x off_y vrender1 | r run two lines and check
# p pos then 16 expected line buffer words {pal,colour} at pos..pos+15, 00f is empty
# empty table, list ends at entry 0
w 0 0000 8000 0000 0000
s 0 000 000 080
r
# 1x1 with scroll offset, then 1x1 with abs_pos
w 0 00a0 0085 0120 0003
w 1 0100 007e 0205 0081
w 2 0000 8000 0000 0000
s 0 010 008 080
p 050 063 064 065 066 067 068 069 06a 06b 06c 06d 06e 00f 060 061 062
p 0c0 027 028 029 02a 02b 02c 02d 02e 00f 020 021 022 023 024 025 026
r
# 3 wide, then 3 wide with hflip
w 0 0060 0040 0030 0200
w 1 0100 0040 0030 0221
w 2 0000 8000 0000 0000
s 0 000 000 040
p 020 000 001 002 003 004 005 006 007 008 009 00a 00b 00c 00d 00e 00f
p 030 001 002 003 004 005 006 007 008 009 00a 00b 00c 00d 00e 00f 000
p 040 002 003 004 005 006 007 008 009 00a 00b 00c 00d 00e 00f 000 001
p 0c0 021 020 00f 02e 02d 02c 02b 02a 029 028 027 026 025 024 023 022
p 0d0 020 00f 02e 02d 02c 02b 02a 029 028 027 026 025 024 023 022 021
p 0e0 00f 02e 02d 02c 02b 02a 029 028 027 026 025 024 023 022 021 020
r
# 2 tall on second row, same with vflip, one object off the line
w 0 0080 003d 0040 1002
w 1 0100 003d 0044 1041
w 2 0140 0100 0000 0000
w 3 0000 8000 0000 0000
s 0 000 000 050
p 040 043 044 045 046 047 048 049 04a 04b 04c 04d 04e 00f 040 041 042
p 0c0 020 021 022 023 024 025 026 027 028 029 02a 02b 02c 02d 02e 00f
r
# overlap, earlier entry wins, entry 3 lies past the end marker
w 0 0080 0020 0005 0001
w 1 0088 0020 0000 0002
w 2 0000 8000 0000 0000
w 3 0100 0020 0000 0003
s 0 000 000 020
p 040 025 026 027 028 029 02a 02b 02c 02d 02e 042 020 021 022 023 024
p 050 048 049 04a 04b 04c 04d 04e 00f 00f 00f 00f 00f 00f 00f 00f 00f
r

//--- list.f
verilog/obj_pkg.sv
verilog/obj_table.sv
verilog/obj_tile_match.sv
verilog/obj_scan.sv
verilog/obj_draw.sv
verilog/obj_line_buf.sv
verilog/obj_engine.sv
bench/obj_engine_tb.sv

//--- run.sh
#!/bin/sh
# build and run the object engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module obj_engine_tb -f list.f -o obj_engine_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/obj_engine_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^Testbench passed$"; then
    exit 0
fi
exit 1

//--- verilog/obj_draw.sv
// tile row renderer
// fetches two 32-bit halves of a row from ROM and writes 16 pixels
// to the line buffer, transparent ones skipped
`timescale 1ns/1ps
`default_nettype none

module obj_draw import obj_pkg::*; (
    input  wire              rst,
    input  wire              clk,
    input  wire              dr_start,
    input  wire  [15:0]      dr_code,
    input  wire  obj_attr_u  dr_attr,
    input  wire  [8:0]       dr_hpos,
    input  wire  [1:0]       dr_bank,
    input  wire  [31:0]      rom_data,
    input  wire              rom_ok,
    output logic             dr_idle,
    output logic [22:0]      rom_addr,   // bank, code, vsub, half
    output logic             rom_cs,
    output logic             buf_we,
    output logic [8:0]       buf_addr,
    output logic [BUF_W-1:0] buf_data
);
    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_FETCH = 2'd1;
    localparam logic [1:0] ST_DRAW  = 2'd2;

    logic [1:0]       st;
    logic             half;
    logic [2:0]       cnt;        // pixel inside the half
    logic [31:0]      pxls;
    obj_attr_u        cur_attr;
    logic [8:0]       cur_hpos;
    logic [3:0]       pos;
    logic [PXL_W-1:0] col;

    assign pos = cur_attr.drw.hflip ? ~{half, cnt} : {half, cnt};
    assign col = pxls[PXL_W-1:0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st      <= ST_IDLE;
            half    <= 1'b0;
            cnt     <= '0;
            dr_idle <= 1'b1;
            rom_cs  <= 1'b0;
            buf_we  <= 1'b0;
        end else begin
            buf_we <= 1'b0;
            case (st)
                ST_IDLE: if (dr_start) begin
                    dr_idle <= 1'b0;
                    rom_cs  <= 1'b1;
                    half    <= 1'b0;
                    st      <= ST_FETCH;
                end
                ST_FETCH: if (rom_ok) begin   // address held until here
                    rom_cs <= 1'b0;
                    cnt    <= '0;
                    st     <= ST_DRAW;
                end
                ST_DRAW: begin
                    buf_we <= col != TRANSP;
                    cnt    <= cnt + 1'b1;
                    if (&cnt) begin
                        if (!half) begin
                            half   <= 1'b1;
                            rom_cs <= 1'b1;
                            st     <= ST_FETCH;
                        end else begin
                            dr_idle <= 1'b1;
                            st      <= ST_IDLE;
                        end
                    end
                end
                default: st <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (st == ST_IDLE && dr_start) begin
            cur_attr <= dr_attr;
            cur_hpos <= dr_hpos;
            rom_addr <= {dr_bank, dr_code, dr_attr.drw.vsub, 1'b0};
        end
        if (st == ST_FETCH && rom_ok) begin
            pxls <= rom_data;
        end
        if (st == ST_DRAW) begin
            pxls     <= pxls >> PXL_W;       // pixel 0 in the low nibble
            buf_addr <= cur_hpos + {5'd0, pos};
            buf_data <= {cur_attr.drw.pal, col};
            if (&cnt && !half) begin
                rom_addr[0] <= 1'b1;         // second half of the row
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/obj_engine.sv
// object line engine top level
// frame table, scanner, renderer and double line buffer
`timescale 1ns/1ps
`default_nettype none

module obj_engine import obj_pkg::*; #(
    parameter int         TABLE_AW = 10,
    parameter logic [8:0] START_H  = 9'h1d0
) (
    input  wire                  rst,
    input  wire                  clk,
    input  wire                  flip,
    input  wire  [8:0]           vrender1,
    input  wire  [8:0]           hdump,
    input  wire  [9:0]           off_x,
    input  wire  [9:0]           off_y,
    input  wire                  cpu_we,
    input  wire  [TABLE_AW+1:0]  cpu_addr,
    input  wire  [15:0]          cpu_data,
    output logic [22:0]          rom_addr,
    output logic                 rom_cs,
    input  wire  [31:0]          rom_data,
    input  wire                  rom_ok,
    input  wire  [8:0]           pxl_addr,
    output logic [BUF_W-1:0]     pxl_data,
    output logic                 line
);
    logic [TABLE_AW-1:0] table_addr;
    logic [15:0]         table_x, table_y, table_code, table_attr;

    logic                dr_start, dr_idle;
    logic [15:0]         dr_code;
    obj_attr_u           dr_attr;
    logic [8:0]          dr_hpos;
    logic [1:0]          dr_bank;

    logic                buf_we;
    logic [8:0]          buf_addr;
    logic [BUF_W-1:0]    buf_data;

    obj_table #(.TABLE_AW(TABLE_AW)) u_table (
        .clk        (clk),
        .cpu_we     (cpu_we),
        .cpu_addr   (cpu_addr),
        .cpu_data   (cpu_data),
        .table_addr (table_addr),
        .table_x    (table_x),
        .table_y    (table_y),
        .table_code (table_code),
        .table_attr (table_attr)
    );

    obj_scan #(.TABLE_AW(TABLE_AW), .START_H(START_H)) u_scan (
        .rst        (rst),
        .clk        (clk),
        .flip       (flip),
        .vrender1   (vrender1),
        .hdump      (hdump),
        .off_x      (off_x),
        .off_y      (off_y),
        .table_x    (table_x),
        .table_y    (table_y),
        .table_code (table_code),
        .table_attr (table_attr),
        .dr_idle    (dr_idle),
        .line       (line),
        .table_addr (table_addr),
        .dr_start   (dr_start),
        .dr_code    (dr_code),
        .dr_attr    (dr_attr),
        .dr_hpos    (dr_hpos),
        .dr_bank    (dr_bank)
    );

    obj_draw u_draw (
        .rst      (rst),
        .clk      (clk),
        .dr_start (dr_start),
        .dr_code  (dr_code),
        .dr_attr  (dr_attr),
        .dr_hpos  (dr_hpos),
        .dr_bank  (dr_bank),
        .rom_data (rom_data),
        .rom_ok   (rom_ok),
        .dr_idle  (dr_idle),
        .rom_addr (rom_addr),
        .rom_cs   (rom_cs),
        .buf_we   (buf_we),
        .buf_addr (buf_addr),
        .buf_data (buf_data)
    );

    obj_line_buf u_line_buf (
        .rst      (rst),
        .clk      (clk),
        .line     (line),
        .buf_we   (buf_we),
        .buf_addr (buf_addr),
        .buf_data (buf_data),
        .pxl_addr (pxl_addr),
        .pxl_data (pxl_data)
    );

endmodule

`default_nettype wire

//--- verilog/obj_line_buf.sv
// double line buffer
// one half takes renderer writes, first writer wins
// the other half is read by the display and wiped after each read
`timescale 1ns/1ps
`default_nettype none

module obj_line_buf import obj_pkg::*; (
    input  wire              rst,
    input  wire              clk,
    input  wire              line,
    input  wire              buf_we,
    input  wire  [8:0]       buf_addr,
    input  wire  [BUF_W-1:0] buf_data,
    input  wire  [8:0]       pxl_addr,
    output logic [BUF_W-1:0] pxl_data
);
    localparam logic [BUF_W-1:0] EMPTY = BUF_W'(TRANSP);

    logic [BUF_W-1:0] mem [0:1023];

    logic [9:0] wr_a, rd_a;
    logic [9:0] erase_a;     // slot read on the previous clock
    logic [9:0] clr_a;
    logic       clr_busy;    // sweep of both halves after reset
    logic [9:0] wipe_a;
    logic       free;

    assign wr_a   = {line, buf_addr};
    assign rd_a   = {~line, pxl_addr};
    assign wipe_a = clr_busy ? clr_a : erase_a;
    assign free   = mem[wr_a][PXL_W-1:0] == TRANSP;

    // takes 1024 clocks before the buffer is clean
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            clr_busy <= 1'b1;
            clr_a    <= '0;
        end else if (clr_busy) begin
            clr_a <= clr_a + 1'b1;
            if (&clr_a) begin
                clr_busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        pxl_data <= mem[rd_a];
        erase_a  <= rd_a;
        if (buf_we && free) begin
            mem[wr_a] <= buf_data;
        end
        mem[wipe_a] <= EMPTY;
    end

endmodule

`default_nettype wire

//--- verilog/obj_pkg.sv
// shared types and constants for the object line engine
// attribute word in table and draw views, pixel and buffer widths
`default_nettype none

package obj_pkg;

    localparam int PXL_W = 4;              // colour index width
    localparam int PAL_W = 5;
    localparam int BUF_W = PAL_W + PXL_W;  // palette and colour

    localparam logic [PXL_W-1:0] TRANSP = 4'd15;

    // attribute word as the CPU writes it in the frame table
    typedef struct packed {
        logic [3:0]       tile_m;   // vertical tiles minus one
        logic [3:0]       tile_n;   // horizontal tiles minus one
        logic             abs_pos;  // no scroll offset
        logic             vflip;
        logic             hflip;
        logic [PAL_W-1:0] pal;
    } obj_attr_tbl_s;

    // attribute word as the scanner hands it to the renderer
    typedef struct packed {
        logic [3:0]       zero;
        logic [3:0]       vsub;     // row inside the tile
        logic             abs_pos;
        logic             vflip;
        logic             hflip;
        logic [PAL_W-1:0] pal;
    } obj_attr_drw_s;

    typedef union packed {
        obj_attr_tbl_s tbl;
        obj_attr_drw_s drw;
    } obj_attr_u;

endpackage

`default_nettype wire

//--- verilog/obj_scan.sv
// per-line frame table scanner
// four-stage walk through address, scroll offset and list end, tile match
// and horizontal expansion into one draw request per tile
// runs on a divide-by-two enable because of the table output latch
`timescale 1ns/1ps
`default_nettype none

module obj_scan import obj_pkg::*; #(
    parameter int         TABLE_AW = 10,
    parameter logic [8:0] START_H  = 9'h1d0
) (
    input  wire                  rst,
    input  wire                  clk,
    input  wire                  flip,
    input  wire  [8:0]           vrender1,   // two lines ahead of display
    input  wire  [8:0]           hdump,
    input  wire  [9:0]           off_x,
    input  wire  [9:0]           off_y,
    input  wire  [15:0]          table_x,
    input  wire  [15:0]          table_y,
    input  wire  [15:0]          table_code,
    input  wire  [15:0]          table_attr,
    input  wire                  dr_idle,
    output logic                 line,
    output logic [TABLE_AW-1:0]  table_addr,
    output logic                 dr_start,
    output logic [15:0]          dr_code,
    output obj_attr_u            dr_attr,
    output logic [8:0]           dr_hpos,
    output logic [1:0]           dr_bank
);
    logic        cen;
    logic        start, last_start, start_req;
    logic        done;
    logic [8:0]  vrenderf;

    obj_attr_u   tbl_attr;
    logic        end_obj;

    logic [15:0] st3_code;
    obj_attr_u   st3_attr;
    logic [9:0]  st3_x, st3_y;
    logic [1:0]  st3_bank;

    obj_attr_u   st4_attr;
    logic [9:0]  st4_x;
    logic [1:0]  st4_bank;
    logic [3:0]  st4_vsub;
    logic [15:0] code_mn;
    logic        inzone;

    logic [3:0]  n;          // horizontal tile being requested
    logic [3:0]  subn;
    logic [9:0]  st4_effx;
    logic        more;
    logic        stall;

    obj_tile_match u_tile_match (
        .rst      (rst),
        .clk      (clk),
        .cen      (cen & ~stall),
        .obj_code (st3_code),
        .attr     (st3_attr),
        .vrenderf (vrenderf),
        .obj_y    (st3_y),
        .vsub     (st4_vsub),
        .inzone   (inzone),
        .code_mn  (code_mn)
    );

    assign start    = hdump == START_H;
    assign tbl_attr = table_attr;
    assign end_obj  = table_y[15] || (table_attr[15:8] == 8'hff) || (&table_addr);

    // hflip places the first tile on the right
    assign subn     = st4_attr.tbl.hflip ? st4_attr.tbl.tile_n - n : n;
    assign st4_effx = st4_x + {2'b0, subn, 4'd0};
    assign more     = n != st4_attr.tbl.tile_n;
    assign stall    = inzone && (!dr_idle || more);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cen <= 1'b0;
        end else begin
            cen <= ~cen;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last_start <= 1'b0;
            start_req  <= 1'b0;
            line       <= 1'b0;
            done       <= 1'b1;
            vrenderf   <= '0;
            table_addr <= '0;
            n          <= '0;
            dr_start   <= 1'b0;
            dr_code    <= '0;
            dr_attr    <= '0;
            dr_hpos    <= '0;
            dr_bank    <= '0;
            st3_code   <= '0;
            st3_attr   <= '0;
            st3_x      <= '0;
            st3_y      <= '0;
            st3_bank   <= '0;
            st4_attr   <= '0;
            st4_x      <= '0;
            st4_bank   <= '0;
        end else begin
            last_start <= start;
            if (cen) begin
                start_req <= 1'b0;
                if (!stall) begin
                    table_addr <= done ? '0 : table_addr + 1'b1;
                    if (done || end_obj) begin
                        done     <= 1'b1;
                        st3_y    <= 10'h200;  // keeps the blank entry out of zone
                        st3_attr <= '0;
                    end else begin
                        st3_code <= table_code;
                        st3_x    <= table_x[9:0] - 10'h40 -
                                    (tbl_attr.tbl.abs_pos ? 10'd0 : off_x);
                        st3_y    <= table_y[9:0] - (tbl_attr.tbl.abs_pos ? 10'd0 : off_y);
                        st3_attr <= tbl_attr;
                        st3_bank <= table_y[14:13];
                    end
                    st4_attr <= st3_attr;
                    st4_x    <= st3_x;
                    st4_bank <= st3_bank;
                end
                // one draw request per enable while the renderer is free
                if (inzone && dr_idle) begin
                    dr_attr  <= {4'd0, st4_vsub, st4_attr[7:0]};
                    dr_code  <= {code_mn[15:4], code_mn[3:0] + n};
                    dr_hpos  <= st4_effx[8:0];
                    dr_bank  <= st4_bank;
                    dr_start <= !st4_effx[9];   // off the right edge
                    n        <= more ? n + 1'b1 : 4'd0;
                end else begin
                    dr_start <= 1'b0;
                end
                if (start_req) begin
                    line       <= ~line;
                    vrenderf   <= vrender1 ^ {1'b0, {8{flip}}};
                    n          <= '0;
                    done       <= 1'b0;
                    table_addr <= '0;
                end
            end
            if (start && !last_start) begin
                start_req <= 1'b1;  // held until the next enable
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/obj_table.sv
// frame table RAM
// CPU writes one 16-bit word at a time, read port returns a whole entry
`timescale 1ns/1ps
`default_nettype none

module obj_table #(
    parameter int TABLE_AW = 10
) (
    input  wire                  clk,
    input  wire                  cpu_we,
    input  wire  [TABLE_AW+1:0]  cpu_addr,   // entry and word select
    input  wire  [15:0]          cpu_data,
    input  wire  [TABLE_AW-1:0]  table_addr,
    output logic [15:0]          table_x,
    output logic [15:0]          table_y,
    output logic [15:0]          table_code,
    output logic [15:0]          table_attr
);
    localparam int DEPTH = 2 ** TABLE_AW;

    logic [15:0] mem_x    [0:DEPTH-1];
    logic [15:0] mem_y    [0:DEPTH-1];
    logic [15:0] mem_code [0:DEPTH-1];
    logic [15:0] mem_attr [0:DEPTH-1];

    logic [TABLE_AW-1:0] wr_entry;

    assign wr_entry = cpu_addr[TABLE_AW+1:2];

    always_ff @(posedge clk) begin
        if (cpu_we) begin
            case (cpu_addr[1:0])
                2'd0:    mem_x[wr_entry]    <= cpu_data;
                2'd1:    mem_y[wr_entry]    <= cpu_data;
                2'd2:    mem_code[wr_entry] <= cpu_data;
                default: mem_attr[wr_entry] <= cpu_data;
            endcase
        end
    end

    // output latch loads every clock
    always_ff @(posedge clk) begin
        table_x    <= mem_x[table_addr];
        table_y    <= mem_y[table_addr];
        table_code <= mem_code[table_addr];
        table_attr <= mem_attr[table_addr];
    end

endmodule

`default_nettype wire

//--- verilog/obj_tile_match.sv
// vertical match for one object
// finds the tile row crossing the current line, its sub-row and base code
`timescale 1ns/1ps
`default_nettype none

module obj_tile_match import obj_pkg::*; (
    input  wire              rst,
    input  wire              clk,
    input  wire              cen,
    input  wire  [15:0]      obj_code,
    input  wire  obj_attr_u  attr,
    input  wire  [8:0]       vrenderf,
    input  wire  [9:0]       obj_y,
    output logic [3:0]       vsub,
    output logic             inzone,
    output logic [15:0]      code_mn
);
    logic [9:0] ycross;    // line distance from the object top
    logic [3:0] row;
    logic [3:0] m;         // tile row after flipping
    logic       hit;

    assign ycross = {1'b0, vrenderf} - obj_y;
    assign row    = ycross[7:4];

    // object height is (tile_m+1)*16 lines, never above 256
    assign hit = (ycross[9:8] == 2'd0) && (row <= attr.tbl.tile_m);
    assign m   = attr.tbl.vflip ? attr.tbl.tile_m - row : row;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            inzone <= 1'b0;
        end else if (cen) begin
            inzone <= hit;
        end
    end

    always_ff @(posedge clk) begin
        if (cen) begin
            vsub    <= attr.tbl.vflip ? ~ycross[3:0] : ycross[3:0];
            code_mn <= obj_code + {8'd0, m, 4'd0};  // 16 codes per tile row
        end
    end

endmodule

`default_nettype wire
